// ==== vlog.f ====
+incdir+logic
logic/md5Pkg.sv
logic/md5MessagePad.sv
logic/md5Step.sv
logic/md5Finalize.sv
logic/md5Pipeline.sv
tb/md5PipelineTb.sv

// ==== Bender.yml ====
package:
  name: md5_pipeline

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/md5Pkg.sv
      - logic/md5MessagePad.sv
      - logic/md5Step.sv
      - logic/md5Finalize.sv
      - logic/md5Pipeline.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/md5PipelineTb.sv

// ==== tb/md5PipelineTb.sv ====
`timescale 1ns/1ns
`include "md5_defines.svh"

module md5PipelineTb import md5Pkg::*; ();

	// Driving cycle to output cycle
	localparam int latency = 66;
	localparam int drainLimit = 200;

	logic clk;
	logic rstN;
	logic inValid;
	md5Guess guess;
	md5Len guessLen;
	logic outValid;
	md5State digest;

	int cycleCount = 0;
	int errorCount = 0;
	int checkCount = 0;
	int outCount = 0;
	logic [31:0] lfsrState = 32'd77281;

	// Expected results in input order, with their due cycle
	int dueQ [$];
	md5State expQ [$];

	md5Word sineTab [0:63];
	int shiftRule [0:3][0:3] = '{
		'{7, 12, 17, 22},
		'{5, 9, 14, 20},
		'{4, 11, 16, 23},
		'{6, 10, 15, 21}
	};

	md5Pipeline md5Pipeline_i (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.guess(guess),
		.guessLen(guessLen),
		.outValid(outValid),
		.digest(digest)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) cycleCount <= cycleCount + 1;

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	function automatic logic [127:0] randomBits(input int n);
		logic [127:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[126:0], lfsrState[0]};
		end
		return v;
	endfunction

	task automatic buildSineTable();
		real s;
		for (int i = 0; i < 64; i++) begin
			s = $sin(i + 1);
			if (s < 0.0) begin
				s = -s;
			end
			sineTab[i] = md5Word'(longint'($floor(s * 4294967296.0)));
		end
	endtask

	function automatic md5Word rotl(input md5Word x, input int n);
		return (x << n) | (x >> (32 - n));
	endfunction

	// Full MD5 of one padded block holding the first len bytes
	function automatic md5State md5Ref(input md5Guess guessIn, input md5Len len);
		logic [7:0] blk [0:63];
		md5Word m [0:15];
		md5Word a, b, c, d, f, tmp;
		int r, i, idx;
		md5State res;
		for (int k = 0; k < 64; k++) begin
			blk[k] = 8'h00;
		end
		for (int k = 0; k < len; k++) begin
			blk[k] = guessIn[127 - 8 * k -: 8];
		end
		blk[len] = 8'h80;
		// Bit length never exceeds one byte here
		blk[56] = 8'(int'(len) * 8);
		for (int j = 0; j < 16; j++) begin
			m[j] = {blk[4 * j + 3], blk[4 * j + 2], blk[4 * j + 1], blk[4 * j]};
		end
		a = `MD5_IV_A;
		b = `MD5_IV_B;
		c = `MD5_IV_C;
		d = `MD5_IV_D;
		for (int k = 0; k < 64; k++) begin
			r = k / 16;
			i = k % 16;
			case (r)
				0: begin
					f = (b & c) | (~b & d);
					idx = i;
				end
				1: begin
					f = (d & b) | (~d & c);
					idx = (5 * i + 1) % 16;
				end
				2: begin
					f = b ^ c ^ d;
					idx = (3 * i + 5) % 16;
				end
				default: begin
					f = c ^ (b | ~d);
					idx = (7 * i) % 16;
				end
			endcase
			tmp = d;
			d = c;
			c = b;
			b = b + rotl(a + f + sineTab[k] + m[idx], shiftRule[r][k % 4]);
			a = tmp;
		end
		res.a = a + `MD5_IV_A;
		res.b = b + `MD5_IV_B;
		res.c = c + `MD5_IV_C;
		res.d = d + `MD5_IV_D;
		return res;
	endfunction

	// Published hex digest, read as little-endian words
	function automatic md5State publishedToState(input logic [127:0] h);
		md5Word w [0:3];
		for (int j = 0; j < 4; j++) begin
			w[j] = {h[127 - 8 * (4 * j + 3) -: 8], h[127 - 8 * (4 * j + 2) -: 8],
				h[127 - 8 * (4 * j + 1) -: 8], h[127 - 8 * (4 * j) -: 8]};
		end
		return '{a: w[0], b: w[1], c: w[2], d: w[3]};
	endfunction

	task automatic checkDigest(input string name, input md5State expVal, input md5State actVal);
		checkCount++;
		if (actVal !== expVal) begin
			errorCount++;
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
		end
	endtask

	task automatic checkValid(input string name, input logic expVal, input logic actVal);
		checkCount++;
		if (actVal !== expVal) begin
			errorCount++;
			$display("Error at %0t ns: %s expected %b, got %b", $time, name, expVal, actVal);
		end
	endtask

	task automatic checkOutputs();
		logic expValid;
		if (!rstN) begin
			dueQ.delete();
			expQ.delete();
			checkValid("outValid", 1'b0, outValid);
		end else begin
			expValid = (dueQ.size() > 0) && (dueQ[0] == cycleCount);
			checkValid("outValid", expValid, outValid);
			if (outValid === 1'b1) begin
				outCount++;
			end
			if (expValid) begin
				checkDigest("digest", expQ[0], digest);
				void'(dueQ.pop_front());
				void'(expQ.pop_front());
			end
		end
	endtask

	// Outputs settle well before the next edge
	always begin
		@(posedge clk);
		#2;
		checkOutputs();
	end

	task automatic driveCycle(input logic valid, input md5Guess g, input md5Len len);
		@(posedge clk);
		#1;
		inValid = valid;
		guess = g;
		guessLen = len;
		if (valid && rstN) begin
			dueQ.push_back(cycleCount + latency);
			expQ.push_back(md5Ref(g, len));
		end
	endtask

	task automatic driveRandom(input logic valid);
		md5Guess g;
		md5Len len;
		g = randomBits(128);
		len = md5Len'(randomBits(4));
		driveCycle(valid, g, len);
	endtask

	task automatic resetDut();
		@(posedge clk);
		#1;
		rstN = 1'b0;
		inValid = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rstN = 1'b1;
	endtask

	task automatic waitDrain(input string name);
		for (int n = 0; n < drainLimit && dueQ.size() > 0; n++) begin
			driveCycle(1'b0, '0, '0);
		end
		if (dueQ.size() > 0) begin
			$display("Timeout in %s: %0d results never arrived", name, dueQ.size());
			$display(">>> FAIL");
			$finish;
		end else begin
			repeat (3) driveCycle(1'b0, '0, '0);
		end
	endtask

	task automatic reportTest(input string name, input int chkStart, input int errStart);
		$display("%s: %0d checks, %0d errors", name, checkCount - chkStart,
			errorCount - errStart);
	endtask

	initial begin
		int chkStart;
		int errStart;
		int inCount;
		int outStart;
		md5Guess g1;
		md5Guess g2;
		md5Guess tailMask;
		md5Len len;
		logic valid;

		rstN = 1'b0;
		inValid = 1'b0;
		guess = '0;
		guessLen = '0;
		buildSineTable();
		repeat (8) @(posedge clk);
		#1;
		rstN = 1'b1;

		// Known vectors
		chkStart = checkCount;
		errStart = errorCount;
		checkDigest("model empty", publishedToState(128'hd41d8cd98f00b204e9800998ecf8427e),
			md5Ref('0, 4'd0));
		checkDigest("model abc", publishedToState(128'h900150983cd24fb0d6963f7d28e17f72),
			md5Ref({"abc", 104'h0}, 4'd3));
		driveCycle(1'b1, '0, 4'd0);
		driveCycle(1'b1, {"abc", 104'h0}, 4'd3);
		waitDrain("known vectors");
		reportTest("known vectors", chkStart, errStart);

		// One guess every cycle
		chkStart = checkCount;
		errStart = errorCount;
		repeat (300) driveRandom(1'b1);
		waitDrain("back-to-back stream");
		reportTest("back-to-back stream", chkStart, errStart);

		// Random gaps
		chkStart = checkCount;
		errStart = errorCount;
		inCount = 0;
		outStart = outCount;
		for (int n = 0; n < 300; n++) begin
			valid = 1'(randomBits(1));
			if (valid) begin
				inCount++;
			end
			driveRandom(valid);
		end
		waitDrain("gapped input");
		checkCount++;
		if (outCount - outStart != inCount) begin
			errorCount++;
			$display("Gapped input gave %0d outputs for %0d inputs", outCount - outStart,
				inCount);
		end
		reportTest("gapped input", chkStart, errStart);

		// Same prefix and length, different bytes past the length
		chkStart = checkCount;
		errStart = errorCount;
		for (int n = 0; n < 40; n++) begin
			g1 = randomBits(128);
			len = md5Len'(randomBits(4));
			tailMask = {128{1'b1}} >> (8 * len);
			g2 = g1 ^ ((randomBits(128) | 128'h1) & tailMask);
			checkDigest("model tail pair", md5Ref(g1, len), md5Ref(g2, len));
			driveCycle(1'b1, g1, len);
			driveCycle(1'b1, g2, len);
		end
		waitDrain("ignored tail bytes");
		reportTest("ignored tail bytes", chkStart, errStart);

		// Reset with the pipeline full of work
		chkStart = checkCount;
		errStart = errorCount;
		repeat (30) driveRandom(1'b1);
		resetDut();
		repeat (10) driveCycle(1'b0, '0, '0);
		for (int n = 0; n < 60; n++) begin
			valid = 1'(randomBits(1));
			driveRandom(valid);
		end
		waitDrain("reset while busy");
		reportTest("reset while busy", chkStart, errStart);

		$display("Total: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== logic/md5Pipeline.sv ====
`timescale 1ns/1ns
`include "md5_defines.svh"

module md5Pipeline import md5Pkg::*; (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input md5Guess guess,
	input md5Len guessLen,
	output logic outValid,
	output md5State digest
);

	// Entry 0 from the pad stage, entry k+1 from step k
	md5Item stageItem [0:`MD5_STEPS];

	md5MessagePad md5MessagePad_i (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.guess(guess),
		.guessLen(guessLen),
		.item(stageItem[0])
	);

	for (genvar k = 0; k < `MD5_STEPS; k++) begin : genStep
		md5Step #(
			.stepIdx(k)
		) md5Step_i (
			.clk(clk),
			.rstN(rstN),
			.prev(stageItem[k]),
			.next(stageItem[k+1])
		);
	end

	md5Finalize md5Finalize_i (
		.clk(clk),
		.rstN(rstN),
		.last(stageItem[`MD5_STEPS]),
		.outValid(outValid),
		.digest(digest)
	);

endmodule

// ==== logic/md5Finalize.sv ====
`timescale 1ns/1ns
`include "md5_defines.svh"

module md5Finalize import md5Pkg::*; (
	input logic clk,
	input logic rstN,
	input md5Item last,
	output logic outValid,
	output md5State digest
);

	md5State sumState;

	// Add back the chaining values of the single block
	always_comb begin
		sumState.a = last.state.a + `MD5_IV_A;
		sumState.b = last.state.b + `MD5_IV_B;
		sumState.c = last.state.c + `MD5_IV_C;
		sumState.d = last.state.d + `MD5_IV_D;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= last.valid;
		end
	end

	always_ff @(posedge clk) begin
		digest <= sumState;
	end

endmodule

// ==== logic/md5Step.sv ====
`timescale 1ns/1ns

module md5Step import md5Pkg::*; #(
	parameter int stepIdx = 0
) (
	input logic clk,
	input logic rstN,
	input md5Item prev,
	output md5Item next
);

	localparam int unsigned round = stepIdx / 16;
	localparam int unsigned wordIdx = md5StepWord(stepIdx);
	localparam int unsigned rotAmt = md5StepShift(stepIdx);
	localparam md5Word sineConst = md5StepConst(stepIdx);

	md5Word funcVal;
	md5Word msgWord;
	md5Word sum;
	md5Word rotated;
	md5Word newB;
	logic validQ;
	md5State stateQ;
	md5Msg msgQ;

	// Round boolean function
	always_comb begin
		case (round)
			0: funcVal = (prev.state.b & prev.state.c) | (~prev.state.b & prev.state.d);
			1: funcVal = (prev.state.b & prev.state.d) | (prev.state.c & ~prev.state.d);
			2: funcVal = prev.state.b ^ prev.state.c ^ prev.state.d;
			default: funcVal = prev.state.c ^ (prev.state.b | ~prev.state.d);
		endcase
	end

	// Words 4 to 13 and 15 are always zero for short guesses
	always_comb begin
		case (wordIdx)
			0: msgWord = prev.msg.w0;
			1: msgWord = prev.msg.w1;
			2: msgWord = prev.msg.w2;
			3: msgWord = prev.msg.w3;
			14: msgWord = prev.msg.w14;
			default: msgWord = '0;
		endcase
	end

	assign sum = prev.state.a + funcVal + msgWord + sineConst;
	assign rotated = (sum << rotAmt) | (sum >> ($bits(md5Word) - rotAmt));
	assign newB = prev.state.b + rotated;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validQ <= 1'b0;
		end else begin
			validQ <= prev.valid;
		end
	end

	// State rotates one word per step
	always_ff @(posedge clk) begin
		stateQ <= '{a: prev.state.d, b: newB, c: prev.state.b, d: prev.state.c};
		msgQ <= prev.msg;
	end

	assign next = '{valid: validQ, state: stateQ, msg: msgQ};

endmodule

// ==== logic/md5MessagePad.sv ====
`timescale 1ns/1ns
`include "md5_defines.svh"

module md5MessagePad import md5Pkg::*; (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input md5Guess guess,
	input md5Len guessLen,
	output md5Item item
);

	localparam int numBytes = `MD5_MAX_GUESS + 1;

	// Every block starts from the chaining values
	localparam md5State ivState = '{a: `MD5_IV_A, b: `MD5_IV_B, c: `MD5_IV_C, d: `MD5_IV_D};

	logic [7:0] msgBytes [0:numBytes-1];
	md5Msg padded;
	logic validQ;
	md5Msg msgQ;

	// Guess bytes below the length, the marker at the length, zero after
	always_comb begin
		for (int i = 0; i < numBytes; i++) begin
			if (i < guessLen) begin
				msgBytes[i] = guess[$bits(md5Guess) - 1 - 8 * i -: 8];
			end else if (i == guessLen) begin
				msgBytes[i] = 8'h80;
			end else begin
				msgBytes[i] = 8'h00;
			end
		end
	end

	// Words are little endian, so the first byte lands in the low bits
	always_comb begin
		padded.w0 = {msgBytes[3], msgBytes[2], msgBytes[1], msgBytes[0]};
		padded.w1 = {msgBytes[7], msgBytes[6], msgBytes[5], msgBytes[4]};
		padded.w2 = {msgBytes[11], msgBytes[10], msgBytes[9], msgBytes[8]};
		padded.w3 = {msgBytes[15], msgBytes[14], msgBytes[13], msgBytes[12]};
		// Length in bits
		padded.w14 = md5Word'({guessLen, 3'b000});
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validQ <= 1'b0;
		end else begin
			validQ <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		msgQ <= padded;
	end

	assign item = '{valid: validQ, state: ivState, msg: msgQ};

endmodule

// ==== logic/md5Pkg.sv ====
`include "md5_defines.svh"

package md5Pkg;

	typedef logic [`MD5_WORD_BITS-1:0] md5Word;

	// First message byte sits in the top 8 bits
	typedef logic [127:0] md5Guess;

	// Guess length in bytes
	typedef logic [3:0] md5Len;

	// Running state, and also the digest
	typedef struct packed {
		md5Word a;
		md5Word b;
		md5Word c;
		md5Word d;
	} md5State;

	// Only the words that can be nonzero for short guesses
	typedef struct packed {
		md5Word w0;
		md5Word w1;
		md5Word w2;
		md5Word w3;
		md5Word w14;
	} md5Msg;

	// Payload between pipeline stages
	typedef struct packed {
		logic valid;
		md5State state;
		md5Msg msg;
	} md5Item;

	// floor(abs(sin(i+1)) * 2^32)
	localparam md5Word sineTable [0:63] = '{
		32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
		32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
		32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
		32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
		32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
		32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
		32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
		32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
		32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
		32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
		32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
		32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
		32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
		32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
		32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
		32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
	};

	// Four shifts per round, repeating every four steps
	localparam int unsigned shiftTable [0:15] = '{
		7, 12, 17, 22,
		5, 9, 14, 20,
		4, 11, 16, 23,
		6, 10, 15, 21
	};

	function automatic md5Word md5StepConst(input int unsigned step);
		return sineTable[step];
	endfunction

	function automatic int unsigned md5StepShift(input int unsigned step);
		int unsigned round;
		int unsigned pos;
		round = step / 16;
		pos = step % 4;
		return shiftTable[4 * round + pos];
	endfunction

	// Message word index used by a step
	function automatic int unsigned md5StepWord(input int unsigned step);
		int unsigned i;
		int unsigned idx;
		i = step % 16;
		case (step / 16)
			0: idx = i;
			1: idx = (5 * i + 1) % 16;
			2: idx = (3 * i + 5) % 16;
			default: idx = (7 * i) % 16;
		endcase
		return idx;
	endfunction

endpackage

// ==== logic/md5_defines.svh ====
`ifndef MD5_DEFINES_SVH
`define MD5_DEFINES_SVH

// Datapath word width
`define MD5_WORD_BITS 32

// One step per pipeline stage
`define MD5_STEPS 64

// Longest guess that still fits one padded block with room for the marker
`define MD5_MAX_GUESS 15

// Initial chaining values, as in RFC 1321
`define MD5_IV_A 32'h67452301
`define MD5_IV_B 32'hefcdab89
`define MD5_IV_C 32'h98badcfe
`define MD5_IV_D 32'h10325476

`endif
